//--- hdl/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// register and data path width
`define CSR_DATA_W 32

// csr number field carried by a request
`define CSR_NUM_W 14

`define ECODE_W 6

// external interrupt lines into estat bits 9 to 2
`define HWI_W 8

`define TIMER_W 32

// da set, everything else clear
`define CRMD_RESET 32'h0000_0008

// lie bits 9 to 0 and the timer enable at bit 11
`define LIE_MASK 32'h0000_0bff

`endif

//--- hdl/csr_op_pkg.sv
`include "csr_defines.svh"

package csr_op_pkg;

    // operation carried by a pipeline request
    typedef enum logic [2:0] {
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_ertn,
        op_excp
    } csr_op_e;

    // exception codes as stored in estat
    typedef enum logic [`ECODE_W-1:0] {
        ec_int = 6'h00,
        ec_ale = 6'h09,
        ec_sys = 6'h0b,
        ec_brk = 6'h0c,
        ec_ine = 6'h0d,
        ec_ipe = 6'h0e
    } ecode_e;

endpackage

//--- hdl/csr_reg_pkg.sv
`include "csr_defines.svh"

package csr_reg_pkg;

    // csr numbers of the kept registers
    typedef enum logic [`CSR_NUM_W-1:0] {
        csr_crmd   = 14'h000,
        csr_prmd   = 14'h001,
        csr_ecfg   = 14'h004,
        csr_estat  = 14'h005,
        csr_era    = 14'h006,
        csr_eentry = 14'h00c,
        csr_save0  = 14'h030,
        csr_save1  = 14'h031,
        csr_save2  = 14'h032,
        csr_save3  = 14'h033,
        csr_tid    = 14'h040,
        csr_tcfg   = 14'h041,
        csr_tval   = 14'h042,
        csr_ticlr  = 14'h044,
        // anything not listed above
        csr_none   = 14'h3fff
    } csr_addr_e;

    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    typedef logic [`CSR_DATA_W-1:0] pc_t;

    typedef logic [1:0] plv_t;

endpackage

//--- hdl/csr_decode.sv
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_decode
    import csr_op_pkg::*, csr_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    input  csr_op_e               req_op,
    input  logic [`CSR_NUM_W-1:0] req_csr_num,
    input  csr_data_t             req_wdata,
    input  csr_data_t             req_wmask,
    input  pc_t                   req_pc,
    input  ecode_e                req_ecode,
    input  logic                  stall,
    input  logic                  int_pending,
    output logic                  dec_valid,
    output csr_op_e               dec_op,
    output csr_addr_e             dec_addr,
    output csr_data_t             dec_wdata,
    output csr_data_t             dec_wmask,
    output pc_t                   dec_pc,
    output ecode_e                dec_ecode
);

    logic      accept;
    csr_op_e   eff_op;
    ecode_e    eff_ecode;
    csr_data_t eff_mask;

    function automatic csr_addr_e map_addr(input logic [`CSR_NUM_W-1:0] num);
        csr_addr_e a;
        a = csr_addr_e'(num);
        case (a)
            csr_crmd, csr_prmd, csr_ecfg, csr_estat, csr_era, csr_eentry,
            csr_save0, csr_save1, csr_save2, csr_save3,
            csr_tid, csr_tcfg, csr_tval, csr_ticlr:
                map_addr = a;
            default:
                map_addr = csr_none;
        endcase
    endfunction

    assign accept = req_valid && !stall;

    always_comb
    begin
        eff_op = req_op;
        eff_ecode = req_ecode;
        // pending interrupt takes the slot, pc stays
        if (int_pending)
        begin
            eff_op = op_excp;
            eff_ecode = ec_int;
        end
        case (eff_op)
            op_csrwr:   eff_mask = '1;
            op_csrxchg: eff_mask = req_wmask;
            default:    eff_mask = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            dec_valid <= 1'b0;
        else
            dec_valid <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dec_op <= eff_op;
            dec_addr <= map_addr(req_csr_num);
            dec_wdata <= req_wdata;
            dec_wmask <= eff_mask;
            dec_pc <= req_pc;
            dec_ecode <= eff_ecode;
        end
    end

endmodule

//--- hdl/csr_execute.sv
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_execute
    import csr_op_pkg::*, csr_reg_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic [`HWI_W-1:0] hw_int,
    input  logic              dec_valid,
    input  csr_op_e           dec_op,
    input  csr_addr_e         dec_addr,
    input  csr_data_t         dec_wdata,
    input  csr_data_t         dec_wmask,
    input  pc_t               dec_pc,
    input  ecode_e            dec_ecode,
    output logic              int_pending,
    output logic              exe_valid,
    output csr_op_e           exe_op,
    output csr_data_t         exe_rdata,
    output pc_t               exe_target,
    output plv_t              crmd_plv,
    output logic              crmd_ie
);

    csr_data_t           crmd_q;
    csr_data_t           prmd_q;
    csr_data_t           ecfg_q;
    csr_data_t           era_q;
    csr_data_t           eentry_q;
    csr_data_t           save_q [4];
    csr_data_t           tid_q;
    csr_data_t           tcfg_q;
    logic [1:0]          estat_is_q;
    ecode_e              estat_ecode_q;
    logic                timer_flag_q;
    logic                timer_run_q;
    logic [`TIMER_W-1:0] tval_q;

    csr_data_t estat_val;
    csr_data_t old_val;
    csr_data_t merged;
    logic      csr_write;
    logic      tcfg_wr;
    logic      ticlr_wr;

    assign estat_val = {10'b0, estat_ecode_q, 4'b0, timer_flag_q, 1'b0, hw_int, estat_is_q};

    assign int_pending = crmd_q[2] && |(estat_val[11:0] & ecfg_q[11:0]);

    always_comb
    begin
        case (dec_addr)
            csr_crmd:   old_val = crmd_q;
            csr_prmd:   old_val = prmd_q;
            csr_ecfg:   old_val = ecfg_q;
            csr_estat:  old_val = estat_val;
            csr_era:    old_val = era_q;
            csr_eentry: old_val = eentry_q;
            csr_save0, csr_save1, csr_save2, csr_save3:
                old_val = save_q[dec_addr[1:0]];
            csr_tid:    old_val = tid_q;
            csr_tcfg:   old_val = tcfg_q;
            csr_tval:   old_val = csr_data_t'(tval_q);
            // ticlr and unknown numbers read as zero
            default:    old_val = '0;
        endcase
    end

    assign merged = (old_val & ~dec_wmask) | (dec_wdata & dec_wmask);
    assign csr_write = dec_valid && (dec_op == op_csrwr || dec_op == op_csrxchg);
    assign tcfg_wr = csr_write && dec_addr == csr_tcfg;
    assign ticlr_wr = csr_write && dec_addr == csr_ticlr && merged[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q <= `CRMD_RESET;
            prmd_q <= '0;
            ecfg_q <= '0;
            era_q <= '0;
            eentry_q <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
            tid_q <= '0;
            tcfg_q <= '0;
            estat_is_q <= 2'b00;
            estat_ecode_q <= ec_int;
        end
        else if (dec_valid)
        begin
            case (dec_op)
                op_csrwr, op_csrxchg:
                begin
                    case (dec_addr)
                        csr_crmd:
                        begin
                            crmd_q[2:0] <= merged[2:0];
                            crmd_q[8:5] <= merged[8:5];
                            // da and pg only as a legal pair
                            if (merged[4] ^ merged[3])
                                crmd_q[4:3] <= merged[4:3];
                        end
                        csr_prmd:   prmd_q[2:0] <= merged[2:0];
                        csr_ecfg:   ecfg_q <= merged & `LIE_MASK;
                        csr_estat:  estat_is_q <= merged[1:0];
                        csr_era:    era_q <= merged;
                        csr_eentry: eentry_q <= merged;
                        csr_save0, csr_save1, csr_save2, csr_save3:
                            save_q[dec_addr[1:0]] <= merged;
                        csr_tid:    tid_q <= merged;
                        csr_tcfg:   tcfg_q <= merged;
                        default:    ;
                    endcase
                end
                op_excp:
                begin
                    prmd_q[2:0] <= crmd_q[2:0];
                    crmd_q[2:0] <= 3'b000;
                    era_q <= dec_pc;
                    estat_ecode_q <= dec_ecode;
                end
                op_ertn:
                    crmd_q[2:0] <= prmd_q[2:0];
                default: ;
            endcase
        end
    end

    // one-shot timer stops at zero, periodic reloads
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval_q <= '0;
            timer_run_q <= 1'b0;
            timer_flag_q <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
            begin
                timer_run_q <= merged[0];
                if (merged[0])
                    tval_q <= {merged[`TIMER_W-1:2], 2'b00};
            end
            else if (timer_run_q)
            begin
                if (tval_q != '0)
                    tval_q <= tval_q - 1'b1;
                else if (tcfg_q[1])
                    tval_q <= {tcfg_q[`TIMER_W-1:2], 2'b00};
                else
                    timer_run_q <= 1'b0;
            end
            if (ticlr_wr)
                timer_flag_q <= 1'b0;
            else if (timer_run_q && tval_q == '0)
                timer_flag_q <= 1'b1;
        end
    end

    always_comb
    begin
        case (dec_op)
            op_excp: exe_target = eentry_q;
            op_ertn: exe_target = era_q;
            default: exe_target = dec_pc + 32'd4;
        endcase
    end

    assign exe_valid = dec_valid;
    assign exe_op = dec_op;
    assign exe_rdata = old_val;
    assign crmd_plv = crmd_q[1:0];
    assign crmd_ie = crmd_q[2];

endmodule

//--- hdl/csr_result.sv
`timescale 1ns/100ps

module csr_result
    import csr_op_pkg::*, csr_reg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      exe_valid,
    input  csr_op_e   exe_op,
    input  csr_data_t exe_rdata,
    input  pc_t       exe_target,
    output logic      rdata_valid,
    output csr_data_t rdata,
    output logic      redirect_valid,
    output pc_t       redirect_pc,
    output logic      excp_flush,
    output logic      ertn_flush
);

    logic is_access;
    logic is_redirect;
    logic is_excp;
    logic is_ertn;

    // strobes for the operation in the execute cycle
    always_comb
    begin
        is_access = 1'b0;
        is_redirect = 1'b0;
        is_excp = 1'b0;
        is_ertn = 1'b0;
        if (exe_valid)
        begin
            is_access = exe_op == op_csrrd || exe_op == op_csrwr || exe_op == op_csrxchg;
            is_redirect = exe_op != op_csrrd;
            is_excp = exe_op == op_excp;
            is_ertn = exe_op == op_ertn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rdata_valid <= 1'b0;
            redirect_valid <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            rdata_valid <= is_access;
            redirect_valid <= is_redirect;
            excp_flush <= is_excp;
            ertn_flush <= is_ertn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exe_valid)
        begin
            rdata <= exe_rdata;
            redirect_pc <= exe_target;
        end
    end

endmodule

//--- hdl/csr_unit.sv
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit
    import csr_op_pkg::*, csr_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    input  csr_op_e               req_op,
    input  logic [`CSR_NUM_W-1:0] req_csr_num,
    input  csr_data_t             req_wdata,
    input  csr_data_t             req_wmask,
    input  pc_t                   req_pc,
    input  ecode_e                req_ecode,
    input  logic                  stall,
    input  logic [`HWI_W-1:0]     hw_int,
    output logic                  rdata_valid,
    output csr_data_t             rdata,
    output logic                  redirect_valid,
    output pc_t                   redirect_pc,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output plv_t                  crmd_plv,
    output logic                  crmd_ie
);

    logic      int_pending;
    logic      dec_valid;
    csr_op_e   dec_op;
    csr_addr_e dec_addr;
    csr_data_t dec_wdata;
    csr_data_t dec_wmask;
    pc_t       dec_pc;
    ecode_e    dec_ecode;
    logic      exe_valid;
    csr_op_e   exe_op;
    csr_data_t exe_rdata;
    pc_t       exe_target;

    csr_decode u_decode (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_op(req_op), .req_csr_num(req_csr_num),
        .req_wdata(req_wdata), .req_wmask(req_wmask), .req_pc(req_pc),
        .req_ecode(req_ecode), .stall(stall), .int_pending(int_pending),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_addr(dec_addr),
        .dec_wdata(dec_wdata), .dec_wmask(dec_wmask), .dec_pc(dec_pc),
        .dec_ecode(dec_ecode)
    );

    csr_execute u_execute (
        .clk(clk), .rstn(rstn), .hw_int(hw_int),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_addr(dec_addr),
        .dec_wdata(dec_wdata), .dec_wmask(dec_wmask), .dec_pc(dec_pc),
        .dec_ecode(dec_ecode), .int_pending(int_pending),
        .exe_valid(exe_valid), .exe_op(exe_op), .exe_rdata(exe_rdata),
        .exe_target(exe_target), .crmd_plv(crmd_plv), .crmd_ie(crmd_ie)
    );

    csr_result u_result (
        .clk(clk), .rstn(rstn),
        .exe_valid(exe_valid), .exe_op(exe_op), .exe_rdata(exe_rdata),
        .exe_target(exe_target), .rdata_valid(rdata_valid), .rdata(rdata),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush)
    );

endmodule

//--- verif/csr_unit_checker.sv
`timescale 1ns/100ps

module csr_unit_checker
(
    input logic clk,
    input logic rstn,
    input logic rdata_valid,
    input logic redirect_valid,
    input logic excp_flush,
    input logic ertn_flush
);

    // polled by the testbench monitor
    int assert_errors = 0;

    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
    else
    begin
        $error("excp_flush and ertn_flush high in the same cycle");
        assert_errors++;
    end

    // a flush always comes with its redirect
    flush_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> redirect_valid)
    else
    begin
        $error("flush strobe without redirect_valid");
        assert_errors++;
    end

    no_rdata_on_ertn: assert property (@(posedge clk) disable iff (!rstn)
        !(rdata_valid && ertn_flush))
    else
    begin
        $error("rdata_valid together with ertn_flush");
        assert_errors++;
    end

    // one edge into reset all strobes are low
    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !(rdata_valid || redirect_valid || excp_flush || ertn_flush))
    else
    begin
        $error("output strobe high during reset");
        assert_errors++;
    end

endmodule

bind csr_unit csr_unit_checker i_checker (
    .clk(clk),
    .rstn(rstn),
    .rdata_valid(rdata_valid),
    .redirect_valid(redirect_valid),
    .excp_flush(excp_flush),
    .ertn_flush(ertn_flush)
);

//--- verif/csr_unit_tb.sv
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit_tb
    import csr_op_pkg::*, csr_reg_pkg::*;
();

    typedef struct packed {
        logic [3:0]  strobes;
        logic        chk;
        csr_data_t   rdata;
        pc_t         pc;
        logic [31:0] due;
    } expect_t;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    csr_op_e               req_op;
    logic [`CSR_NUM_W-1:0] req_csr_num;
    csr_data_t             req_wdata;
    csr_data_t             req_wmask;
    pc_t                   req_pc;
    ecode_e                req_ecode;
    logic                  stall;
    logic [`HWI_W-1:0]     hw_int;
    logic                  rdata_valid;
    csr_data_t             rdata;
    logic                  redirect_valid;
    pc_t                   redirect_pc;
    logic                  excp_flush;
    logic                  ertn_flush;
    plv_t                  crmd_plv;
    logic                  crmd_ie;

    // reference model state
    csr_data_t m_crmd;
    csr_data_t m_prmd;
    csr_data_t m_ecfg;
    csr_data_t m_era;
    csr_data_t m_eentry;
    csr_data_t m_tid;
    csr_data_t m_tcfg;
    csr_data_t m_save [4];
    logic [1:0] m_is;
    ecode_e    m_ecode;

    expect_t     exp_q [$];
    logic [31:0] cycle;
    logic [31:0] lcg_state;
    csr_data_t   last_rdata;
    string       test_name;

    csr_addr_e targets [10] = '{csr_save0, csr_save1, csr_save2, csr_save3, csr_tid,
                                csr_era, csr_eentry, csr_prmd, csr_ecfg, csr_crmd};

    csr_unit i_dut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_op(req_op),
        .req_csr_num(req_csr_num), .req_wdata(req_wdata), .req_wmask(req_wmask),
        .req_pc(req_pc), .req_ecode(req_ecode), .stall(stall), .hw_int(hw_int),
        .rdata_valid(rdata_valid), .rdata(rdata), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input csr_data_t act, input csr_data_t exp);
        if (act !== exp)
            stop_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    endtask

    task automatic check_pc(input string name, input pc_t act, input pc_t exp);
        if (act !== exp)
            stop_run($sformatf("[ERROR] %s: expected pc 0x%08h, actual 0x%08h", name, exp, act));
    endtask

    task automatic check_ecode(input string name, input ecode_e act, input ecode_e exp);
        if (act !== exp)
            stop_run($sformatf("[ERROR] %s: expected ecode 0x%02h, actual 0x%02h", name, exp, act));
    endtask

    // upper half of the lcg state has the better period
    function automatic logic [15:0] next_rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic csr_data_t next_rand32();
        return {next_rand16(), next_rand16()};
    endfunction

    function automatic csr_data_t model_estat();
        csr_data_t v;
        v = '0;
        v[1:0] = m_is;
        v[9:2] = hw_int;
        v[21:16] = m_ecode;
        return v;
    endfunction

    function automatic csr_data_t model_read(input logic [`CSR_NUM_W-1:0] num);
        case (num)
            csr_crmd:   return m_crmd;
            csr_prmd:   return m_prmd;
            csr_ecfg:   return m_ecfg;
            csr_estat:  return model_estat();
            csr_era:    return m_era;
            csr_eentry: return m_eentry;
            csr_save0, csr_save1, csr_save2, csr_save3:
                return m_save[num[1:0]];
            csr_tid:    return m_tid;
            csr_tcfg:   return m_tcfg;
            // tval is only checked by bound in the timer test
            default:    return '0;
        endcase
    endfunction

    task automatic model_write(input logic [`CSR_NUM_W-1:0] num, input csr_data_t merged);
        case (num)
            csr_crmd:
            begin
                m_crmd[2:0] = merged[2:0];
                m_crmd[8:5] = merged[8:5];
                if (merged[4] != merged[3])
                    m_crmd[4:3] = merged[4:3];
            end
            csr_prmd:   m_prmd[2:0] = merged[2:0];
            csr_ecfg:   m_ecfg = merged & `LIE_MASK;
            csr_estat:  m_is = merged[1:0];
            csr_era:    m_era = merged;
            csr_eentry: m_eentry = merged;
            csr_save0, csr_save1, csr_save2, csr_save3:
                m_save[num[1:0]] = merged;
            csr_tid:    m_tid = merged;
            csr_tcfg:   m_tcfg = merged;
            default:    ;
        endcase
    endtask

    task automatic model_accept(input csr_op_e op, input logic [`CSR_NUM_W-1:0] num,
                                input csr_data_t wdata, input csr_data_t wmask,
                                input pc_t pc, input ecode_e code, input logic chk);
        expect_t   e;
        csr_data_t old;
        csr_data_t mask;
        // an enabled pending interrupt takes over the request
        if (m_crmd[2] && (model_estat() & m_ecfg & 32'h0000_0fff) != 0)
        begin
            op = op_excp;
            code = ec_int;
        end
        mask = (op == op_csrwr) ? 32'hffff_ffff : (op == op_csrxchg) ? wmask : 32'h0;
        old = model_read(num);
        e.strobes = {op == op_csrrd || op == op_csrwr || op == op_csrxchg,
                     op != op_csrrd, op == op_excp, op == op_ertn};
        e.chk = chk;
        e.rdata = old;
        e.pc = (op == op_excp) ? m_eentry : (op == op_ertn) ? m_era : pc + 32'd4;
        e.due = cycle + 1;
        exp_q.push_back(e);
        if (op == op_excp)
        begin
            m_prmd[2:0] = m_crmd[2:0];
            m_crmd[2:0] = 3'b000;
            m_era = pc;
            m_ecode = code;
        end
        else if (op == op_ertn)
            m_crmd[2:0] = m_prmd[2:0];
        else if (op != op_csrrd)
            model_write(num, (old & ~mask) | (wdata & mask));
    endtask

    task automatic issue(input csr_op_e op, input logic [`CSR_NUM_W-1:0] num,
                         input csr_data_t wdata, input csr_data_t wmask,
                         input pc_t pc, input ecode_e code, input logic chk);
        int gap;
        gap = next_rand16() % 3;
        req_valid = 1'b1;
        req_op = op;
        req_csr_num = num;
        req_wdata = wdata;
        req_wmask = wmask;
        req_pc = pc;
        req_ecode = code;
        // request held while stalled
        repeat (gap)
        begin
            stall = 1'b1;
            @(posedge clk);
            #2;
        end
        stall = 1'b0;
        @(posedge clk);
        #2;
        model_accept(op, num, wdata, wmask, pc, code, chk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #2;
            n++;
            if (n > 40)
                stop_run("timeout: requests in flight never produced their results");
        end
    endtask

    task automatic read_csr(input logic [`CSR_NUM_W-1:0] num, input logic chk);
        issue(op_csrrd, num, '0, '0, next_rand32() & ~32'h3, ec_sys, chk);
        wait_idle();
    endtask

    task automatic write_csr(input logic [`CSR_NUM_W-1:0] num, input csr_data_t data);
        issue(op_csrwr, num, data, '0, next_rand32() & ~32'h3, ec_sys, 1'b1);
        wait_idle();
    endtask

    always @(negedge clk)
    begin
        expect_t e;
        if (rstn)
        begin
            if (i_dut.i_checker.assert_errors != 0)
                stop_run("a bound assertion on the DUT outputs failed");
            if (exp_q.size() != 0 && exp_q[0].due < cycle)
                stop_run({test_name, ": result did not appear two cycles after accept"});
            if (rdata_valid || redirect_valid || excp_flush || ertn_flush)
            begin
                if (exp_q.size() == 0 || exp_q[0].due != cycle)
                    stop_run({test_name, ": output strobe with no result due"});
                e = exp_q.pop_front();
                check_data({test_name, " strobes"},
                           {28'b0, rdata_valid, redirect_valid, excp_flush, ertn_flush},
                           {28'b0, e.strobes});
                if (rdata_valid && e.chk)
                    check_data({test_name, " rdata"}, rdata, e.rdata);
                if (redirect_valid)
                    check_pc({test_name, " redirect"}, redirect_pc, e.pc);
                last_rdata = rdata;
            end
        end
    end

    initial
    begin
        csr_addr_e num;
        csr_data_t wdata;
        pc_t       pc;
        int        polls;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_op = op_csrrd;
        req_csr_num = '0;
        req_wdata = '0;
        req_wmask = '0;
        req_pc = '0;
        req_ecode = ec_int;
        stall = 1'b0;
        hw_int = '0;
        cycle = '0;
        lcg_state = 32'd47494;
        last_rdata = '0;
        m_crmd = `CRMD_RESET;
        m_prmd = '0;
        m_ecfg = '0;
        m_era = '0;
        m_eentry = '0;
        m_tid = '0;
        m_tcfg = '0;
        m_save = '{default: '0};
        m_is = 2'b00;
        m_ecode = ec_int;
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;

        // every number up to ticlr, unknown ones read zero
        test_name = "reset values";
        for (int n = 0; n <= 'h44; n++)
            issue(op_csrrd, 14'(n), '0, '0, 32'h1c00_0000 + 4 * n, ec_sys, 1'b1);
        read_csr(14'h3fff, 1'b1);
        check_data("reset plv ie", {29'b0, crmd_ie, crmd_plv}, 32'h0);

        test_name = "random csr ops";
        for (int i = 0; i < 300; i++)
        begin
            num = targets[next_rand16() % 10];
            wdata = next_rand32();
            if (num == csr_crmd)
                wdata[2] = 1'b0;
            pc = next_rand32() & ~32'h3;
            issue(csr_op_e'(3'(next_rand16() % 3)), num, wdata, next_rand32(), pc, ec_ine,
                  1'b1);
            if (next_rand16() % 3 == 0)
            begin
                @(posedge clk);
                #2;
            end
        end
        wait_idle();
        check_data("random crmd ie", {31'b0, crmd_ie}, {31'b0, m_crmd[2]});
        check_data("random crmd plv", {30'b0, crmd_plv}, {30'b0, m_crmd[1:0]});

        test_name = "exception entry";
        write_csr(csr_eentry, 32'h1c00_8000);
        write_csr(csr_crmd, 32'h0000_0007);
        pc = 32'h1c00_1230;
        issue(op_excp, csr_crmd, '0, '0, pc, ec_sys, 1'b1);
        wait_idle();
        check_data("exception plv", {30'b0, crmd_plv}, 32'h0);
        read_csr(csr_era, 1'b1);
        check_pc("exception era", last_rdata, pc);
        read_csr(csr_estat, 1'b1);
        check_ecode("exception ecode", ecode_e'(last_rdata[21:16]), ec_sys);
        read_csr(csr_prmd, 1'b1);
        check_data("exception prmd", last_rdata & 32'h7, 32'h7);
        test_name = "exception return";
        issue(op_ertn, csr_crmd, '0, '0, 32'h1c00_4000, ec_sys, 1'b1);
        wait_idle();
        check_data("return plv ie", {29'b0, crmd_ie, crmd_plv}, 32'h7);

        test_name = "hardware interrupt";
        write_csr(csr_ecfg, 32'h0000_0004);
        write_csr(csr_crmd, 32'h0000_0004);
        hw_int = 8'h01;
        pc = 32'h1c00_2000;
        issue(op_csrrd, csr_save1, '0, '0, pc, ec_sys, 1'b1);
        wait_idle();
        hw_int = 8'h00;
        read_csr(csr_era, 1'b1);
        check_pc("hw interrupt era", last_rdata, pc);
        read_csr(csr_estat, 1'b1);
        check_ecode("hw interrupt ecode", ecode_e'(last_rdata[21:16]), ec_int);
        issue(op_ertn, csr_crmd, '0, '0, 32'h1c00_2100, ec_sys, 1'b1);
        wait_idle();

        test_name = "software interrupt";
        write_csr(csr_ecfg, 32'h0000_0001);
        write_csr(csr_estat, 32'h0000_0001);
        pc = 32'h1c00_3000;
        issue(op_csrrd, csr_tid, '0, '0, pc, ec_sys, 1'b1);
        wait_idle();
        read_csr(csr_era, 1'b1);
        check_pc("sw interrupt era", last_rdata, pc);
        read_csr(csr_estat, 1'b1);
        check_ecode("sw interrupt ecode", ecode_e'(last_rdata[21:16]), ec_int);
        // clear is before returning
        issue(op_csrxchg, csr_estat, '0, 32'h3, 32'h1c00_3100, ec_sys, 1'b1);
        issue(op_ertn, csr_crmd, '0, '0, 32'h1c00_3200, ec_sys, 1'b1);
        wait_idle();

        test_name = "timer";
        write_csr(csr_crmd, 32'h0);
        issue(op_csrwr, csr_tcfg, 32'h0000_0021, '0, 32'h1c00_5000, ec_sys, 1'b1);
        issue(op_csrrd, csr_tval, '0, '0, 32'h1c00_5004, ec_sys, 1'b0);
        wait_idle();
        if (last_rdata > 32'h20)
            stop_run($sformatf("[ERROR] timer tval: expected at most 0x00000020, actual 0x%08h",
                               last_rdata));
        polls = 0;
        do
        begin
            read_csr(csr_estat, 1'b0);
            polls++;
            if (polls > 100)
                stop_run("timeout: timer flag in ESTAT bit 11 never set");
        end
        while (!last_rdata[11]);
        write_csr(csr_ticlr, 32'h1);
        read_csr(csr_estat, 1'b1);
        check_data("timer flag clear", last_rdata & 32'h800, 32'h0);

        // assertions on the last edges are not yet seen by the monitor
        if (i_dut.i_checker.assert_errors != 0)
            stop_run("a bound assertion on the DUT outputs failed");
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- csr_unit.f
+incdir+hdl
hdl/csr_op_pkg.sv
hdl/csr_reg_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_result.sv
hdl/csr_unit.sv
verif/csr_unit_checker.sv
verif/csr_unit_tb.sv
